// ==== hw/sram_macros.svh ====
`ifndef SRAM_MACROS_SVH
`define SRAM_MACROS_SVH

// First byte address of the SRAM window
`define SRAM_BASE_ADDR 32'h8000_0000

// Number of 32x512 banks
`define SRAM_NUM_BLOCKS 14

// Words in each bank
`define SRAM_BLOCK_WORDS 512

`endif

// ==== hw/sram_pkg.sv ====
`default_nettype none

package sram_pkg;

    // Data word carried on every port
    typedef logic [31:0] sram_word_t;

    // Byte address as seen by the managers
    typedef logic [31:0] sram_addr_t;

    // One enable bit per byte lane
    typedef logic [3:0] sram_be_t;

    // Access type of an OBI request
    typedef enum logic
    {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } obi_op_e;

    // Data manager that owns the shared port
    typedef enum logic
    {
        OWNER_A = 1'b0,
        OWNER_B = 1'b1
    } arb_owner_e;

endpackage

`default_nettype wire

// ==== hw/obi_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface obi_if
    import sram_pkg::*;
();

    // Request channel
    logic       req;
    logic       gnt;
    sram_addr_t addr;
    obi_op_e    op;
    sram_be_t   be;
    sram_word_t wdata;

    // Response channel, no back-pressure
    logic       rvalid;
    sram_word_t rdata;

    modport manager
    (
        output req,
        output addr,
        output op,
        output be,
        output wdata,
        input  gnt,
        input  rvalid,
        input  rdata
    );

    modport subordinate
    (
        input  req,
        input  addr,
        input  op,
        input  be,
        input  wdata,
        output gnt,
        output rvalid,
        output rdata
    );

endinterface

`default_nettype wire

// ==== hw/sram_bank.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "sram_macros.svh"

module sram_bank
    import sram_pkg::*;
#(
    parameter int unsigned WORDS = `SRAM_BLOCK_WORDS,
    localparam int unsigned AW   = $clog2(WORDS)
)
(
    input  logic          clk_i,

    // Read-write port
    input  logic          rw_cs_i,
    input  logic          rw_we_i,
    input  sram_be_t      rw_be_i,
    input  logic [AW-1:0] rw_addr_i,
    input  sram_word_t    rw_wdata_i,
    output sram_word_t    rw_rdata_o,

    // Read-only port
    input  logic          r_cs_i,
    input  logic [AW-1:0] r_addr_i,
    output sram_word_t    r_rdata_o
);

    sram_word_t mem_q [WORDS];

    // Old word is captured before the masked write lands
    always_ff @(posedge clk_i)
    begin
        if (rw_cs_i)
        begin
            rw_rdata_o <= mem_q[rw_addr_i];
            if (rw_we_i)
            begin
                for (int b = 0; b < 4; b++)
                begin
                    if (rw_be_i[b])
                    begin
                        mem_q[rw_addr_i][8*b +: 8] <= rw_wdata_i[8*b +: 8];
                    end
                end
            end
        end
    end

    // Sees pre-write contents on a same-word collision
    always_ff @(posedge clk_i)
    begin
        if (r_cs_i)
        begin
            r_rdata_o <= mem_q[r_addr_i];
        end
    end

endmodule

`default_nettype wire

// ==== hw/sram_wrap.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "sram_macros.svh"

module sram_wrap
    import sram_pkg::*;
(
    input  logic       clk_i,
    input  logic       reset_i,
    obi_if.subordinate data_bus,
    obi_if.subordinate instr_bus,
    output logic       illegal_memory_o
);

    localparam int unsigned NUM_BANKS   = `SRAM_NUM_BLOCKS;
    localparam int unsigned WORD_BITS   = $clog2(`SRAM_BLOCK_WORDS);
    localparam int unsigned BANK_LSB    = WORD_BITS + 2;
    localparam int unsigned BANK_BITS   = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;
    localparam sram_addr_t  BASE_ADDR   = `SRAM_BASE_ADDR;
    localparam sram_addr_t  RANGE_BYTES = sram_addr_t'(NUM_BANKS * `SRAM_BLOCK_WORDS * 4);

    sram_addr_t             data_offs;
    sram_addr_t             instr_offs;
    logic                   data_in_range;
    logic                   instr_in_range;
    logic                   data_ok;
    logic                   instr_ok;
    logic                   data_we;
    logic [BANK_BITS-1:0]   data_bank;
    logic [BANK_BITS-1:0]   instr_bank;
    logic [WORD_BITS-1:0]   data_word;
    logic [WORD_BITS-1:0]   instr_word;
    logic [NUM_BANKS-1:0]   data_cs;
    logic [NUM_BANKS-1:0]   instr_cs;
    logic [NUM_BANKS-1:0]   data_sel_q;
    logic [NUM_BANKS-1:0]   instr_sel_q;
    sram_word_t             data_rd_vec  [NUM_BANKS];
    sram_word_t             instr_rd_vec [NUM_BANKS];

    // No wait states
    assign data_bus.gnt  = data_bus.req;
    assign instr_bus.gnt = instr_bus.req;

    assign data_offs  = data_bus.addr - BASE_ADDR;
    assign instr_offs = instr_bus.addr - BASE_ADDR;

    // Upper bound is exclusive
    assign data_in_range  = (data_bus.addr >= BASE_ADDR) && (data_offs < RANGE_BYTES);
    assign instr_in_range = (instr_bus.addr >= BASE_ADDR) && (instr_offs < RANGE_BYTES);

    assign data_ok  = data_bus.req && data_in_range;
    assign instr_ok = instr_bus.req && instr_in_range && (instr_bus.op == OP_READ);
    assign data_we  = (data_bus.op == OP_WRITE);

    assign illegal_memory_o = (data_bus.req && !data_in_range) || (instr_bus.req && !instr_ok);

    assign data_bank  = data_offs[BANK_LSB +: BANK_BITS];
    assign instr_bank = instr_offs[BANK_LSB +: BANK_BITS];
    assign data_word  = data_offs[2 +: WORD_BITS];
    assign instr_word = instr_offs[2 +: WORD_BITS];

    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            data_bus.rvalid  <= 1'b0;
            instr_bus.rvalid <= 1'b0;
            data_sel_q       <= '0;
            instr_sel_q      <= '0;
        end
        else
        begin
            data_bus.rvalid  <= data_bus.req;
            instr_bus.rvalid <= instr_bus.req;
            // Writes answer with zero data
            data_sel_q       <= data_cs & {NUM_BANKS{!data_we}};
            instr_sel_q      <= instr_cs;
        end
    end

    // Read mux driven by last cycle's selects
    always_comb
    begin
        data_bus.rdata  = '0;
        instr_bus.rdata = '0;
        for (int i = 0; i < int'(NUM_BANKS); i++)
        begin
            if (data_sel_q[i])
            begin
                data_bus.rdata = data_rd_vec[i];
            end
            if (instr_sel_q[i])
            begin
                instr_bus.rdata = instr_rd_vec[i];
            end
        end
    end

    for (genvar g = 0; g < NUM_BANKS; g++)
    begin : g_bank
        assign data_cs[g]  = data_ok && (data_bank == BANK_BITS'(g));
        assign instr_cs[g] = instr_ok && (instr_bank == BANK_BITS'(g));

        sram_bank #(
            .WORDS (`SRAM_BLOCK_WORDS)
        ) bank_i (
            .clk_i      (clk_i),
            .rw_cs_i    (data_cs[g]),
            .rw_we_i    (data_we),
            .rw_be_i    (data_bus.be),
            .rw_addr_i  (data_word),
            .rw_wdata_i (data_bus.wdata),
            .rw_rdata_o (data_rd_vec[g]),
            .r_cs_i     (instr_cs[g]),
            .r_addr_i   (instr_word),
            .r_rdata_o  (instr_rd_vec[g])
        );
    end

endmodule

`default_nettype wire

// ==== hw/obi_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module obi_arbiter
    import sram_pkg::*;
(
    input  logic       clk_i,
    input  logic       reset_i,
    obi_if.subordinate mgr_a,
    obi_if.subordinate mgr_b,
    obi_if.manager     sub
);

    arb_owner_e winner;
    arb_owner_e last_owner_q;
    arb_owner_e resp_owner_q;
    logic       xfer;

    // Round robin only matters under contention
    always_comb
    begin
        if (mgr_a.req && mgr_b.req)
        begin
            winner = (last_owner_q == OWNER_A) ? OWNER_B : OWNER_A;
        end
        else if (mgr_b.req)
        begin
            winner = OWNER_B;
        end
        else
        begin
            winner = OWNER_A;
        end
    end

    always_comb
    begin
        sub.req = mgr_a.req || mgr_b.req;
        if (winner == OWNER_B)
        begin
            sub.addr  = mgr_b.addr;
            sub.op    = mgr_b.op;
            sub.be    = mgr_b.be;
            sub.wdata = mgr_b.wdata;
        end
        else
        begin
            sub.addr  = mgr_a.addr;
            sub.op    = mgr_a.op;
            sub.be    = mgr_a.be;
            sub.wdata = mgr_a.wdata;
        end
    end

    // Loser keeps req up until its turn
    assign mgr_a.gnt = sub.gnt && mgr_a.req && (winner == OWNER_A);
    assign mgr_b.gnt = sub.gnt && mgr_b.req && (winner == OWNER_B);

    assign xfer = sub.req && sub.gnt;

    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            last_owner_q <= OWNER_B;
            resp_owner_q <= OWNER_A;
        end
        else if (xfer)
        begin
            last_owner_q <= winner;
            resp_owner_q <= winner;
        end
    end

    // Response goes back to whoever owned last cycle's transfer
    assign mgr_a.rvalid = sub.rvalid && (resp_owner_q == OWNER_A);
    assign mgr_b.rvalid = sub.rvalid && (resp_owner_q == OWNER_B);
    assign mgr_a.rdata  = mgr_a.rvalid ? sub.rdata : '0;
    assign mgr_b.rdata  = mgr_b.rvalid ? sub.rdata : '0;

endmodule

`default_nettype wire

// ==== hw/sram_subsys_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module sram_subsys_top
    import sram_pkg::*;
(
    input  logic       clk_i,
    input  logic       reset_i,

    // Instruction fetch, read only
    input  logic       instr_req_i,
    output logic       instr_gnt_o,
    input  sram_addr_t instr_addr_i,
    input  obi_op_e    instr_op_i,
    output logic       instr_rvalid_o,
    output sram_word_t instr_rdata_o,

    // Core data port
    input  logic       da_req_i,
    output logic       da_gnt_o,
    input  sram_addr_t da_addr_i,
    input  obi_op_e    da_op_i,
    input  sram_be_t   da_be_i,
    input  sram_word_t da_wdata_i,
    output logic       da_rvalid_o,
    output sram_word_t da_rdata_o,

    // DMA / debug data port
    input  logic       db_req_i,
    output logic       db_gnt_o,
    input  sram_addr_t db_addr_i,
    input  obi_op_e    db_op_i,
    input  sram_be_t   db_be_i,
    input  sram_word_t db_wdata_i,
    output logic       db_rvalid_o,
    output sram_word_t db_rdata_o,

    output logic       illegal_memory_o
);

    obi_if instr_if ();
    obi_if port_a_if ();
    obi_if port_b_if ();
    obi_if data_if ();

    assign instr_if.req   = instr_req_i;
    assign instr_if.addr  = instr_addr_i;
    assign instr_if.op    = instr_op_i;
    // No write data on the fetch side
    assign instr_if.be    = '0;
    assign instr_if.wdata = '0;
    assign instr_gnt_o    = instr_if.gnt;
    assign instr_rvalid_o = instr_if.rvalid;
    assign instr_rdata_o  = instr_if.rdata;

    assign port_a_if.req   = da_req_i;
    assign port_a_if.addr  = da_addr_i;
    assign port_a_if.op    = da_op_i;
    assign port_a_if.be    = da_be_i;
    assign port_a_if.wdata = da_wdata_i;
    assign da_gnt_o        = port_a_if.gnt;
    assign da_rvalid_o     = port_a_if.rvalid;
    assign da_rdata_o      = port_a_if.rdata;

    assign port_b_if.req   = db_req_i;
    assign port_b_if.addr  = db_addr_i;
    assign port_b_if.op    = db_op_i;
    assign port_b_if.be    = db_be_i;
    assign port_b_if.wdata = db_wdata_i;
    assign db_gnt_o        = port_b_if.gnt;
    assign db_rvalid_o     = port_b_if.rvalid;
    assign db_rdata_o      = port_b_if.rdata;

    obi_arbiter arbiter_i (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .mgr_a   (port_a_if),
        .mgr_b   (port_b_if),
        .sub     (data_if)
    );

    sram_wrap wrap_i (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .data_bus         (data_if),
        .instr_bus        (instr_if),
        .illegal_memory_o (illegal_memory_o)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_sram_subsys.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "sram_macros.svh"

module tb_sram_subsys
    import sram_pkg::*;
();

    localparam int MAX_CASES = 64;

    logic clk_i;
    logic reset_i;
    logic instr_req_i, instr_gnt_o, instr_rvalid_o;
    sram_addr_t instr_addr_i;
    obi_op_e instr_op_i;
    sram_word_t instr_rdata_o;
    logic da_req_i, da_gnt_o, da_rvalid_o;
    sram_addr_t da_addr_i;
    obi_op_e da_op_i;
    sram_be_t da_be_i;
    sram_word_t da_wdata_i, da_rdata_o;
    logic db_req_i, db_gnt_o, db_rvalid_o;
    sram_addr_t db_addr_i;
    obi_op_e db_op_i;
    sram_be_t db_be_i;
    sram_word_t db_wdata_i, db_rdata_o;
    logic illegal_memory_o;

    // Case table
    logic [8*24-1:0] c_name [MAX_CASES];
    logic [8*4-1:0]  c_port [MAX_CASES];
    int              c_op   [MAX_CASES];
    sram_addr_t      c_addr [MAX_CASES];
    sram_be_t        c_be   [MAX_CASES];
    logic [8*12-1:0] c_wtok [MAX_CASES];
    logic [8*12-1:0] c_etok [MAX_CASES];
    int              c_ill  [MAX_CASES];
    int              num_cases;

    sram_word_t ref_mem [sram_addr_t];
    // Byte lanes of each word that have been written so far
    sram_be_t   ref_known [sram_addr_t];
    arb_owner_e exp_last;
    int         cycles;
    int         limit;
    int         errs;
    int         pass_cnt;
    int         fail_cnt;

    sram_subsys_top dut_i (.*);

    always #5 clk_i = ~clk_i;

    always @(posedge clk_i)
    begin
        cycles <= cycles + 1;
        if (cycles >= limit)
        begin
            $display("Run stopped after %0d cycles, a test never finished", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic check_word(input string name, input sram_word_t exp, input sram_word_t act);
        if (exp !== act)
        begin
            $display("FAILED %s expected %08h actual %08h", name, exp, act);
            errs++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act)
        begin
            $display("FAILED %s illegal expected %0b actual %0b", name, exp, act);
            errs++;
        end
    endtask

    task automatic check_owner(input string name, input arb_owner_e exp, input arb_owner_e act);
        if (exp !== act)
        begin
            $display("FAILED %s owner expected %s actual %s", name, exp.name(), act.name());
            errs++;
        end
    endtask

    task automatic report_result(input string name);
        if (errs == 0)
        begin
            pass_cnt++;
            $display("ok     %s", name);
        end
        else
        begin
            fail_cnt++;
            $display("failed %s", name);
        end
    endtask

    function automatic sram_word_t merge_bytes(sram_word_t old, sram_word_t wd, sram_be_t be);
        sram_word_t res;
        res = old;
        for (int b = 0; b < 4; b++)
        begin
            if (be[b])
            begin
                res[8*b +: 8] = wd[8*b +: 8];
            end
        end
        return res;
    endfunction

    // Port index 0 is I, 1 is A, 2 is B
    function automatic logic port_gnt(int p);
        return (p == 0) ? instr_gnt_o : (p == 1) ? da_gnt_o : db_gnt_o;
    endfunction

    function automatic logic port_rvalid(int p);
        return (p == 0) ? instr_rvalid_o : (p == 1) ? da_rvalid_o : db_rvalid_o;
    endfunction

    function automatic sram_word_t port_rdata(int p);
        return (p == 0) ? instr_rdata_o : (p == 1) ? da_rdata_o : db_rdata_o;
    endfunction

    task automatic drive_port(int p, logic req, sram_addr_t a, obi_op_e op, sram_be_t be,
                              sram_word_t wd);
        case (p)
            0:
            begin
                instr_req_i  = req;
                instr_addr_i = a;
                instr_op_i   = op;
            end
            1:
            begin
                da_req_i   = req;
                da_addr_i  = a;
                da_op_i    = op;
                da_be_i    = be;
                da_wdata_i = wd;
            end
            default:
            begin
                db_req_i   = req;
                db_addr_i  = a;
                db_op_i    = op;
                db_be_i    = be;
                db_wdata_i = wd;
            end
        endcase
    endtask

    // First contention out of reset goes to A, then B follows uncontended
    task automatic contend_after_reset();
        logic a_first;
        errs = 0;
        @(negedge clk_i);
        drive_port(1, 1'b1, `SRAM_BASE_ADDR, OP_READ, '0, '0);
        drive_port(2, 1'b1, `SRAM_BASE_ADDR, OP_READ, '0, '0);
        #1;
        a_first = da_gnt_o;
        check_owner("reset_owner", OWNER_A, a_first ? OWNER_A : OWNER_B);
        @(negedge clk_i);
        drive_port(a_first ? 1 : 2, 1'b0, '0, OP_READ, '0, '0);
        @(negedge clk_i);
        drive_port(1, 1'b0, '0, OP_READ, '0, '0);
        drive_port(2, 1'b0, '0, OP_READ, '0, '0);
        exp_last = OWNER_B;
        report_result("reset_owner");
    endtask

    task automatic run_case(int k);
        string      name;
        logic       used [3];
        logic       pend [3];
        logic       wait_rsp [3];
        sram_addr_t addr [3];
        obi_op_e    op [3];
        sram_word_t wd [3];
        sram_word_t exp [3];
        sram_word_t keep [3];
        sram_word_t got [3];
        sram_word_t base_wd;
        logic       first_gnt;
        logic       ill_seen;
        int         tries;
        arb_owner_e exp_win;
        arb_owner_e act_win;
        name = $sformatf("%0s", c_name[k]);
        errs = 0;
        first_gnt = 1'b1;
        ill_seen = 1'b0;
        tries = 0;
        exp_win = OWNER_A;
        if (c_wtok[k] == "R")
        begin
            base_wd = $urandom;
        end
        else
        begin
            void'($sscanf(c_wtok[k], "%h", base_wd));
        end
        for (int p = 0; p < 3; p++)
        begin
            used[p] = 1'b0;
            wait_rsp[p] = 1'b0;
            got[p] = '0;
            addr[p] = c_addr[k];
            op[p] = obi_op_e'(c_op[k]);
            wd[p] = base_wd;
        end
        used[0] = (c_port[k] == "I") || (c_port[k] == "IA");
        used[1] = (c_port[k] == "A") || (c_port[k] == "AB") || (c_port[k] == "IA");
        used[2] = (c_port[k] == "B") || (c_port[k] == "AB");
        if (c_port[k] == "IA")
        begin
            op[0] = OP_READ;
        end
        if (c_port[k] == "AB")
        begin
            addr[2] = c_addr[k] + 4;
            wd[2] = ~base_wd;
        end
        // Round robin hands contention to the port that was not granted last
        if (used[1] && used[2])
        begin
            exp_win = (exp_last == OWNER_A) ? OWNER_B : OWNER_A;
        end
        // Expected data comes from memory before this case's writes
        for (int p = 0; p < 3; p++)
        begin
            keep[p] = '1;
            if (op[p] == OP_WRITE || c_ill[k] != 0)
            begin
                exp[p] = '0;
            end
            else if (c_etok[k] == "M")
            begin
                exp[p] = ref_mem.exists(addr[p]) ? ref_mem[addr[p]] : '0;
                // Bytes never written hold whatever the bank powered up with
                keep[p] = ref_known.exists(addr[p]) ? merge_bytes('0, '1, ref_known[addr[p]])
                                                    : '0;
            end
            else
            begin
                void'($sscanf(c_etok[k], "%h", exp[p]));
            end
            pend[p] = used[p];
        end
        @(negedge clk_i);
        for (int p = 0; p < 3; p++)
        begin
            if (used[p])
            begin
                drive_port(p, 1'b1, addr[p], op[p], c_be[k], wd[p]);
            end
        end
        while (pend[0] || pend[1] || pend[2] || wait_rsp[0] || wait_rsp[1] || wait_rsp[2])
        begin
            #1;
            for (int p = 0; p < 3; p++)
            begin
                if (wait_rsp[p])
                begin
                    wait_rsp[p] = 1'b0;
                    if (port_rvalid(p))
                    begin
                        got[p] = port_rdata(p);
                    end
                    else
                    begin
                        $display("%s: port %0d got no rvalid one cycle after its gnt", name, p);
                        errs++;
                    end
                end
            end
            if (first_gnt && (port_gnt(0) || port_gnt(1) || port_gnt(2)))
            begin
                first_gnt = 1'b0;
                ill_seen = illegal_memory_o;
                if (used[1] && used[2])
                begin
                    act_win = da_gnt_o ? OWNER_A : OWNER_B;
                    check_owner(name, exp_win, act_win);
                end
            end
            if (da_gnt_o && db_gnt_o)
            begin
                $display("%s: both data ports granted in one cycle", name);
                errs++;
            end
            for (int p = 0; p < 3; p++)
            begin
                if (pend[p] && port_gnt(p))
                begin
                    pend[p] = 1'b0;
                    wait_rsp[p] = 1'b1;
                end
            end
            tries++;
            if ((pend[0] || pend[1] || pend[2]) && tries > 4)
            begin
                $display("%s: request not granted within 4 cycles", name);
                errs++;
                break;
            end
            @(negedge clk_i);
            for (int p = 0; p < 3; p++)
            begin
                if (!pend[p])
                begin
                    drive_port(p, 1'b0, '0, OP_READ, '0, '0);
                end
            end
        end
        for (int p = 0; p < 3; p++)
        begin
            drive_port(p, 1'b0, '0, OP_READ, '0, '0);
            if (used[p])
            begin
                check_word(name, exp[p] & keep[p], got[p] & keep[p]);
                if (op[p] == OP_WRITE && c_ill[k] == 0)
                begin
                    ref_mem[addr[p]] = merge_bytes(ref_mem.exists(addr[p]) ? ref_mem[addr[p]]
                                                   : '0, wd[p], c_be[k]);
                    ref_known[addr[p]] = (ref_known.exists(addr[p]) ? ref_known[addr[p]] : '0)
                                         | c_be[k];
                end
            end
        end
        // The loser of a contention is granted last
        if (used[1] && used[2])
        begin
            exp_last = (exp_win == OWNER_A) ? OWNER_B : OWNER_A;
        end
        else if (used[1])
        begin
            exp_last = OWNER_A;
        end
        else if (used[2])
        begin
            exp_last = OWNER_B;
        end
        check_flag(name, logic'(c_ill[k] != 0), ill_seen);
        report_result(name);
    endtask

    task automatic load_cases();
        int          fd;
        int          n;
        logic [8*160-1:0] line;
        fd = $fopen("testbench/sram_cases.txt", "r");
        num_cases = 0;
        if (fd == 0)
        begin
            $display("Cannot open testbench/sram_cases.txt");
            return;
        end
        while (!$feof(fd) && num_cases < MAX_CASES)
        begin
            line = '0;
            void'($fgets(line, fd));
            n = $sscanf(line, "%s %s %d %h %h %s %s %d", c_name[num_cases],
                        c_port[num_cases], c_op[num_cases], c_addr[num_cases],
                        c_be[num_cases], c_wtok[num_cases], c_etok[num_cases],
                        c_ill[num_cases]);
            // Comment lines fail the op field and are skipped
            if (n == 8)
            begin
                num_cases++;
            end
        end
        $fclose(fd);
    endtask

    initial
    begin
        void'($urandom(60));
        clk_i = 1'b0;
        reset_i = 1'b1;
        cycles = 0;
        limit = 1000;
        pass_cnt = 0;
        fail_cnt = 0;
        exp_last = OWNER_B;
        for (int p = 0; p < 3; p++)
        begin
            drive_port(p, 1'b0, '0, OP_READ, '0, '0);
        end
        load_cases();
        limit = num_cases * 8 + 100;
        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;
        if (num_cases == 0)
        begin
            $display("No test cases were read");
            fail_cnt++;
        end
        contend_after_reset();
        for (int k = 0; k < num_cases; k++)
        begin
            run_case(k);
        end
        $display("Tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0)
        begin
            $display("Simulation passed");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+hw
hw/sram_pkg.sv
hw/obi_if.sv
hw/sram_bank.sv
hw/sram_wrap.sv
hw/obi_arbiter.sv
hw/sram_subsys_top.sv
testbench/tb_sram_subsys.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_sram_subsys
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only -Wall
PASS_MSG  ?= Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module sram_subsys_top
	$(VERILATOR) $(LINTFLAGS) --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== testbench/sram_cases.txt ====
# name port(I A B AB IA) op(0 read, 1 write) addr be wdata(R random) rdata(M reference) illegal
# AB: B uses addr+4 and inverted wdata; IA: I reads addr while A writes it
a_wr_full      A  1 80000000 f 11223344 0        0
a_wr_part      A  1 80000000 5 aabbccdd 0        0
a_rd_merge     A  0 80000000 0 00000000 11bb33dd 0
a_wr_word1     A  1 80000004 f 55667788 0        0
a_wr_hi        A  1 80000004 c 99aabbcc 0        0
a_rd_word1     A  0 80000004 0 00000000 99aa7788 0
b_wr_bank0     B  1 80000010 f deadbeef 0        0
b_wr_bank3     B  1 80001804 f 0badf00d 0        0
b_wr_bank7     B  1 80003808 f 12345678 0        0
b_wr_bank13    B  1 80006ffc f a5a55a5a 0        0
i_rd_bank0     I  0 80000010 0 00000000 deadbeef 0
i_rd_bank3     I  0 80001804 0 00000000 M        0
i_rd_bank7     I  0 80003808 0 00000000 M        0
i_rd_bank13    I  0 80006ffc 0 00000000 a5a55a5a 0
ab_wr_0        AB 1 80000100 f 01020304 0        0
ab_rd_0        AB 0 80000100 0 00000000 M        0
ab_wr_1        AB 1 80002200 f 0f0e0d0c 0        0
ab_rd_1        AB 0 80002200 0 00000000 M        0
ill_below      A  0 7ffffffc 0 00000000 0        1
ill_top        B  0 80007000 0 00000000 0        1
ill_top_wr     A  1 80007000 f ffffffff 0        1
ill_i_write    I  1 80000000 f ffffffff 0        1
chk_unchanged  A  0 80000000 0 00000000 11bb33dd 0
ia_same_word   IA 1 80000010 f cafef00d M        0
i_after_write  I  0 80000010 0 00000000 cafef00d 0
rnd_wr_0       A  1 80002000 f R        0        0
rnd_rd_0       B  0 80002000 0 00000000 M        0
rnd_wr_1       B  1 80005554 6 R        0        0
rnd_rd_1       A  0 80005554 0 00000000 M        0
rnd_wr_2       AB 1 80004440 f R        0        0
rnd_rd_2       AB 0 80004440 0 00000000 M        0
